// ==== project.f ====
common/spim_pkg.sv
common/spim_shift_if.sv
source/spim_fifo.sv
source/spim_sequencer.sv
source/spim_shifter.sv
source/spim_top.sv
tb/spim_slave_model.sv
tb/tb_spim_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module tb_spim_top -o sim_spim > build.log 2>&1
then
    echo "Build failed, see build.log"
    exit 1
fi

if ! ./obj_dir/sim_spim > sim.log 2>&1
then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log
then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

// ==== tb/tb_spim_top.sv ====
// SPI master testbench
// Runs a random command program through the DUT and checks MOSI bits, chip
// selects, received words, end of transfer pulses and SPI clock phases

`timescale 1ns/100ps

module tb_spim_top import spim_pkg::*;;

    logic              clk;
    logic              rst_n;
    logic [WORD_W-1:0] cmd;
    logic              cmd_valid;
    logic              cmd_ready;
    logic [WORD_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_ready;
    logic [WORD_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_ready;
    logic              eot;
    logic              spi_clk;
    logic [CS_N-1:0]   spi_csn;
    logic              spi_sdo;
    logic              spi_sdi;

    logic [WORD_W-1:0] cmd_q[$];
    logic [WORD_W-1:0] tx_q[$];
    logic [WORD_W-1:0] exp_rx_q[$];
    logic [WORD_W-1:0] rx_got_q[$];
    bit                exp_bit_q[$];
    logic [CS_N-1:0]   exp_cs_q[$];
    int                exp_kind_q[$];
    int                wlen_q[$];
    int                wdiv_q[$];
    int                exp_eot = 0;
    int                eot_seen = 0;
    int                total_bits = 0;
    int                limit = 0;
    int                cycles = 0;
    int                errs[6];
    string             names[6];
    int                high_cnt = 0;
    int                low_cnt = 0;
    int                bit_in_word = 0;
    logic              prev_clk = 1'b0;

    spim_top dut
    (
        .sys_clk_i   ( clk       ),
        .rst_n_i     ( rst_n     ),
        .cmd_i       ( cmd       ),
        .cmd_valid_i ( cmd_valid ),
        .cmd_ready_o ( cmd_ready ),
        .tx_data_i   ( tx_data   ),
        .tx_valid_i  ( tx_valid  ),
        .tx_ready_o  ( tx_ready  ),
        .rx_data_o   ( rx_data   ),
        .rx_valid_o  ( rx_valid  ),
        .rx_ready_i  ( rx_ready  ),
        .eot_o       ( eot       ),
        .spi_clk_o   ( spi_clk   ),
        .spi_csn_o   ( spi_csn   ),
        .spi_sdo_o   ( spi_sdo   ),
        .spi_sdi_i   ( spi_sdi   )
    );

    spim_slave_model u_slave
    (
        .spi_clk_i  ( spi_clk ),
        .spi_csn_i  ( spi_csn ),
        .spi_mosi_i ( spi_sdo ),
        .spi_miso_o ( spi_sdi )
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Program generation and expected model
    //////////////////////////////////////////////////

    task automatic add_bit(input bit b, input int chip, input int kind, input bit miso);
        logic [CS_N-1:0] cs;
        // Only the selected chip is low
        cs       = '1;
        cs[chip] = 1'b0;
        exp_bit_q.push_back(b);
        exp_cs_q.push_back(cs);
        exp_kind_q.push_back(kind);
        u_slave.load_bit(miso);
        total_bits++;
    endtask

    task automatic build_program();
        int div;
        int chip;
        int len;
        int n;
        int e;
        logic [LIT_W-1:0]  lit;
        logic [WORD_W-1:0] w;
        for (int r = 0; r < 3; r++)
        begin
            div  = $urandom % 4;
            chip = $urandom % 4;
            cmd_q.push_back({4'd0, 20'd0, 8'(div)});
            cmd_q.push_back({4'd1, 26'd0, 2'(chip)});
            // Unknown opcode is consumed without effect
            cmd_q.push_back({4'hf, 28'd0});
            len = $urandom % 16;
            lit = 16'($urandom);
            cmd_q.push_back({4'd2, 8'd0, 4'(len), lit});
            for (int i = 0; i <= len; i++)
                add_bit(lit[15-i], chip, 1, 1'($urandom));
            wlen_q.push_back(len + 1);
            wdiv_q.push_back(div);
            n = 1 + $urandom % 4;
            cmd_q.push_back({4'd3, 12'd0, 16'(n - 1)});
            for (int k = 0; k < n; k++)
            begin
                w = $urandom;
                tx_q.push_back(w);
                for (int i = 31; i >= 0; i--)
                    add_bit(w[i], chip, 2, 1'($urandom));
                wlen_q.push_back(32);
                wdiv_q.push_back(div);
            end
            n = 1 + $urandom % 4;
            cmd_q.push_back({4'd4, 12'd0, 16'(n - 1)});
            for (int k = 0; k < n; k++)
            begin
                w = $urandom;
                exp_rx_q.push_back(w);
                // The master sends zeros while receiving
                for (int i = 31; i >= 0; i--)
                    add_bit(1'b0, chip, 3, w[i]);
                wlen_q.push_back(32);
                wdiv_q.push_back(div);
            end
            // First two rounds cover both eot settings
            e = (r < 2) ? r : $urandom % 2;
            cmd_q.push_back({4'd5, 27'd0, 1'(e)});
            exp_eot += e;
        end
    endtask

    //////////////////////////////////////////////////
    // Stream drivers
    //////////////////////////////////////////////////

    task automatic feed_cmds();
        foreach (cmd_q[i])
        begin
            cmd       = cmd_q[i];
            cmd_valid = 1'b1;
            @(negedge clk);
            while (!cmd_ready)
                @(negedge clk);
            @(posedge clk);
            #1 cmd_valid = 1'b0;
        end
    endtask

    task automatic feed_tx();
        int gap;
        foreach (tx_q[i])
        begin
            gap = $urandom % 4;
            if (gap > 0)
            begin
                repeat (gap) @(posedge clk);
                #1;
            end
            tx_data  = tx_q[i];
            tx_valid = 1'b1;
            @(negedge clk);
            while (!tx_ready)
                @(negedge clk);
            @(posedge clk);
            #1 tx_valid = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        #1 rx_ready = rst_n ? 1'($urandom) : 1'b0;
    end

    //////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (rx_valid && rx_ready)
                rx_got_q.push_back(rx_data);
            if (eot)
            begin
                eot_seen++;
                assert (spi_csn == '1) else
                begin
                    $display("Mismatch %s: csn at eot expected %b actual %b",
                             names[4], 4'hf, spi_csn);
                    errs[4]++;
                end
            end
            if (spi_clk && !prev_clk)
            begin
                // Only low phases inside a word are timed
                if (bit_in_word > 0)
                    assert (low_cnt == wdiv_q[0] + 1) else
                    begin
                        $display("Mismatch %s: low phase expected %0d actual %0d",
                                 names[5], wdiv_q[0] + 1, low_cnt);
                        errs[5]++;
                    end
                high_cnt = 1;
            end
            else if (spi_clk)
                high_cnt++;
            else if (prev_clk)
            begin
                assert (wdiv_q.size() > 0 && high_cnt == wdiv_q[0] + 1) else
                begin
                    $display("Mismatch %s: high phase expected %0d actual %0d",
                             names[5], wdiv_q.size() > 0 ? wdiv_q[0] + 1 : -1, high_cnt);
                    errs[5]++;
                end
                low_cnt = 1;
                bit_in_word++;
                if (wlen_q.size() > 0 && bit_in_word == wlen_q[0])
                begin
                    void'(wlen_q.pop_front());
                    void'(wdiv_q.pop_front());
                    bit_in_word = 0;
                end
            end
            else
                low_cnt++;
            prev_clk = spi_clk;
        end
    end

    // Run limit from the program length
    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles > limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        int fails;
        int k;
        void'($urandom(23));
        names = '{"reset", "send_cmd", "tx_data", "rx_data", "eot", "divider"};
        foreach (errs[i])
            errs[i] = 0;
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        tx_data   = '0;
        tx_valid  = 1'b0;
        rx_ready  = 1'b0;
        build_program();
        limit = total_bits * 2 * 4 + 200 * cmd_q.size();

        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (spi_csn == '1 && !spi_clk && !eot && !rx_valid) else
        begin
            $display("Mismatch %s: csn/clk/eot/rx_valid expected %b/%b/%b/%b actual %b/%b/%b/%b",
                     names[0], 4'hf, 1'b0, 1'b0, 1'b0, spi_csn, spi_clk, eot, rx_valid);
            errs[0]++;
        end
        $display("test %s: %0d errors", names[0], errs[0]);
        @(posedge clk);
        #1 rst_n = 1'b1;

        fork
            feed_cmds();
            feed_tx();
        join_none
        while (u_slave.mosi_q.size() < total_bits || rx_got_q.size() < exp_rx_q.size())
            @(negedge clk);
        repeat (20) @(negedge clk);

        assert (u_slave.mosi_q.size() == total_bits) else
        begin
            $display("Mismatch %s: bit count expected %0d actual %0d",
                     names[2], total_bits, u_slave.mosi_q.size());
            errs[2]++;
        end
        for (int i = 0; i < total_bits && i < u_slave.mosi_q.size(); i++)
        begin
            k = exp_kind_q[i];
            assert (u_slave.mosi_q[i] == exp_bit_q[i] && u_slave.csn_q[i] == exp_cs_q[i]) else
            begin
                $display("Mismatch %s: bit %0d expected %b/%b actual %b/%b", names[k], i,
                         exp_bit_q[i], exp_cs_q[i], u_slave.mosi_q[i], u_slave.csn_q[i]);
                errs[k]++;
            end
        end
        foreach (exp_rx_q[i])
            assert (i < rx_got_q.size() && rx_got_q[i] == exp_rx_q[i]) else
            begin
                $display("Mismatch %s: word %0d expected %h actual %h", names[3], i,
                         exp_rx_q[i], i < rx_got_q.size() ? rx_got_q[i] : 'x);
                errs[3]++;
            end
        assert (eot_seen == exp_eot) else
        begin
            $display("Mismatch %s: pulses expected %0d actual %0d", names[4], exp_eot, eot_seen);
            errs[4]++;
        end

        fails = 0;
        for (int i = 1; i < 6; i++)
            $display("test %s: %0d errors", names[i], errs[i]);
        foreach (errs[i])
            fails += errs[i];
        $display("tests run: 6, errors in total: %0d", fails);
        if (fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tb/spim_slave_model.sv ====
// Behavioral SPI slave, mode 0
// Records MOSI and chip selects on each rising SPI clock edge and drives
// MISO from a bit queue that the testbench loads ahead of the run

`timescale 1ns/100ps

module spim_slave_model import spim_pkg::*;
(
    input  logic            spi_clk_i,
    input  logic [CS_N-1:0] spi_csn_i,
    input  logic            spi_mosi_i,
    output logic            spi_miso_o
);

    bit              miso_q[$];
    bit              mosi_q[$];
    logic [CS_N-1:0] csn_q[$];

    // Queue one MISO bit, the head of the queue is always on the pin
    task automatic load_bit(input bit b);
        miso_q.push_back(b);
        spi_miso_o = miso_q[0];
    endtask

    always @(posedge spi_clk_i)
    begin
        mosi_q.push_back(spi_mosi_i);
        csn_q.push_back(spi_csn_i);
        // Next MISO bit goes out after the master has sampled this one
        #1;
        if (miso_q.size() > 0)
            void'(miso_q.pop_front());
        if (miso_q.size() > 0)
            spi_miso_o = miso_q[0];
        else
            spi_miso_o = 1'b0;
    end

endmodule

// ==== source/spim_top.sv ====
// SPI master top level
// Command, transmit and receive FIFOs around the command sequencer
// and the single lane shift engine

`timescale 1ns/100ps

module spim_top import spim_pkg::*;
(
    input  logic              sys_clk_i,
    input  logic              rst_n_i,

    input  logic [WORD_W-1:0] cmd_i,
    input  logic              cmd_valid_i,
    output logic              cmd_ready_o,

    input  logic [WORD_W-1:0] tx_data_i,
    input  logic              tx_valid_i,
    output logic              tx_ready_o,

    output logic [WORD_W-1:0] rx_data_o,
    output logic              rx_valid_o,
    input  logic              rx_ready_i,

    output logic              eot_o,

    output logic              spi_clk_o,
    output logic [CS_N-1:0]   spi_csn_o,
    output logic              spi_sdo_o,
    input  logic              spi_sdi_i
);

    logic [WORD_W-1:0] s_cmd;
    logic              s_cmd_valid;
    logic              s_cmd_ready;

    logic [WORD_W-1:0] s_tx_data;
    logic              s_tx_valid;
    logic              s_tx_ready;

    logic [WORD_W-1:0] s_rx_data;
    logic              s_rx_valid;
    logic              s_rx_ready;

    spim_shift_if u_shift_if ();

    //////////////////////////////////////////////////
    // Input and output buffering
    //////////////////////////////////////////////////

    spim_fifo #(.DEPTH(CMD_FIFO_DEPTH)) u_cmd_fifo
    (
        .clk_i        ( sys_clk_i   ),
        .rst_n_i      ( rst_n_i     ),
        .push_data_i  ( cmd_i       ),
        .push_valid_i ( cmd_valid_i ),
        .push_ready_o ( cmd_ready_o ),
        .pop_data_o   ( s_cmd       ),
        .pop_valid_o  ( s_cmd_valid ),
        .pop_ready_i  ( s_cmd_ready )
    );

    spim_fifo #(.DEPTH(TX_FIFO_DEPTH)) u_tx_fifo
    (
        .clk_i        ( sys_clk_i  ),
        .rst_n_i      ( rst_n_i    ),
        .push_data_i  ( tx_data_i  ),
        .push_valid_i ( tx_valid_i ),
        .push_ready_o ( tx_ready_o ),
        .pop_data_o   ( s_tx_data  ),
        .pop_valid_o  ( s_tx_valid ),
        .pop_ready_i  ( s_tx_ready )
    );

    spim_fifo #(.DEPTH(RX_FIFO_DEPTH)) u_rx_fifo
    (
        .clk_i        ( sys_clk_i  ),
        .rst_n_i      ( rst_n_i    ),
        .push_data_i  ( s_rx_data  ),
        .push_valid_i ( s_rx_valid ),
        .push_ready_o ( s_rx_ready ),
        .pop_data_o   ( rx_data_o  ),
        .pop_valid_o  ( rx_valid_o ),
        .pop_ready_i  ( rx_ready_i )
    );

    //////////////////////////////////////////////////
    // Sequencer and shift engine
    //////////////////////////////////////////////////

    spim_sequencer u_seq
    (
        .clk_i       ( sys_clk_i   ),
        .rst_n_i     ( rst_n_i     ),
        .cmd_data_i  ( s_cmd       ),
        .cmd_valid_i ( s_cmd_valid ),
        .cmd_ready_o ( s_cmd_ready ),
        .tx_data_i   ( s_tx_data   ),
        .tx_valid_i  ( s_tx_valid  ),
        .tx_ready_o  ( s_tx_ready  ),
        .rx_data_o   ( s_rx_data   ),
        .rx_valid_o  ( s_rx_valid  ),
        .rx_ready_i  ( s_rx_ready  ),
        .shift       ( u_shift_if  ),
        .spi_csn_o   ( spi_csn_o   ),
        .eot_o       ( eot_o       )
    );

    spim_shifter u_shf
    (
        .clk_i     ( sys_clk_i  ),
        .rst_n_i   ( rst_n_i    ),
        .shift     ( u_shift_if ),
        .spi_clk_o ( spi_clk_o  ),
        .spi_sdo_o ( spi_sdo_o  ),
        .spi_sdi_i ( spi_sdi_i  )
    );

endmodule

// ==== source/spim_shifter.sv ====
// SPI master shift engine
// Mode 0 clock generation from the divider, MSB first transmit on the
// falling edge and receive sampling on the rising edge

`timescale 1ns/100ps

module spim_shifter import spim_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    spim_shift_if.shf shift,

    output logic      spi_clk_o,
    output logic      spi_sdo_o,
    input  logic      spi_sdi_i
);

    logic [DIV_W-1:0]    div_q;
    logic [DIV_W-1:0]    div_cnt_q;
    logic                phase_q;
    logic [BITCNT_W-1:0] bit_cnt_q;
    logic                busy_q;
    logic                done_q;
    logic [WORD_W-1:0]   tx_sr_q;
    logic [WORD_W-1:0]   rx_sr_q;
    logic                half_end;
    logic                rise;
    logic                fall;

    // Each half period lasts div+1 cycles
    assign half_end = busy_q && (div_cnt_q == div_q);
    assign rise     = half_end && !phase_q;
    assign fall     = half_end && phase_q;

    assign spi_clk_o     = phase_q;
    assign spi_sdo_o     = tx_sr_q[WORD_W-1];
    assign shift.busy    = busy_q;
    assign shift.done    = done_q;
    assign shift.rx_word = rx_sr_q;

    //////////////////////////////////////////////////
    // Clock phase and bit counting
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            phase_q   <= 1'b0;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (shift.start)
            begin
                busy_q    <= 1'b1;
                phase_q   <= 1'b0;
                div_cnt_q <= '0;
                bit_cnt_q <= shift.bits;
            end
            else if (busy_q)
            begin
                if (half_end)
                begin
                    div_cnt_q <= '0;
                    phase_q   <= ~phase_q;
                    // Last falling edge closes the word
                    if (fall)
                    begin
                        if (bit_cnt_q == '0)
                        begin
                            busy_q <= 1'b0;
                            done_q <= 1'b1;
                        end
                        else
                            bit_cnt_q <= bit_cnt_q - 1'b1;
                    end
                end
                else
                    div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    // Shift registers, loaded on start
    always_ff @(posedge clk_i)
    begin
        if (shift.start)
        begin
            div_q   <= shift.div;
            tx_sr_q <= shift.tx_word;
            rx_sr_q <= '0;
        end
        else
        begin
            if (rise)
                rx_sr_q <= {rx_sr_q[WORD_W-2:0], spi_sdi_i};
            if (fall)
                tx_sr_q <= {tx_sr_q[WORD_W-2:0], 1'b0};
        end
    end

    a_clk_low_when_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !shift.busy |-> !spi_clk_o);

endmodule

// ==== source/spim_sequencer.sv ====
// SPI master command sequencer
// Decodes the command stream, holds chip select and divider, and issues
// one shift request per word until the command is done

`timescale 1ns/100ps

module spim_sequencer import spim_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic [WORD_W-1:0] cmd_data_i,
    input  logic              cmd_valid_i,
    output logic              cmd_ready_o,

    input  logic [WORD_W-1:0] tx_data_i,
    input  logic              tx_valid_i,
    output logic              tx_ready_o,

    output logic [WORD_W-1:0] rx_data_o,
    output logic              rx_valid_o,
    input  logic              rx_ready_i,

    spim_shift_if.seq         shift,

    output logic [CS_N-1:0]   spi_csn_o,
    output logic              eot_o
);

    seq_state_e         state_q;
    spim_op_e           op;
    logic               multi_word;
    logic [DIV_W-1:0]   div_q;
    logic [CS_N-1:0]    csn_q;
    logic               eot_q;
    logic [CNT_W-1:0]   word_cnt_q;

    // Head of the command FIFO stays put until it is popped
    assign op         = spim_op_e'(cmd_data_i[OP_MSB:OP_LSB]);
    assign multi_word = (op == OP_SEND_CMD) || (op == OP_TX_DATA) || (op == OP_RX_DATA);

    assign spi_csn_o  = csn_q;
    assign eot_o      = eot_q;
    assign shift.div  = div_q;

    //////////////////////////////////////////////////
    // Shift request assembly
    //////////////////////////////////////////////////

    always_comb
    begin
        shift.start   = 1'b0;
        shift.bits    = BITCNT_W'(WORD_W - 1);
        shift.tx_word = '0;
        case (op)
            OP_SEND_CMD:
            begin
                // Literal goes out left aligned
                shift.bits    = BITCNT_W'(cmd_data_i[LEN_LSB +: LEN_W]);
                shift.tx_word = {cmd_data_i[LIT_W-1:0], {(WORD_W - LIT_W){1'b0}}};
                shift.start   = (state_q == EXEC);
            end
            OP_TX_DATA:
            begin
                shift.tx_word = tx_data_i;
                shift.start   = (state_q == EXEC) && tx_valid_i;
            end
            OP_RX_DATA:
                // Room in the rx FIFO now means room at done
                shift.start   = (state_q == EXEC) && rx_ready_i;
            default: ;
        endcase
    end

    assign tx_ready_o = (state_q == EXEC) && (op == OP_TX_DATA);
    assign rx_data_o  = shift.rx_word;
    assign rx_valid_o = (state_q == WAIT_WORD) && shift.done && (op == OP_RX_DATA);

    always_comb
    begin
        case (state_q)
            IDLE:    cmd_ready_o = cmd_valid_i && !multi_word;
            FINISH:  cmd_ready_o = 1'b1;
            default: cmd_ready_o = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q    <= IDLE;
            div_q      <= DIV_W'(DIV_RESET);
            csn_q      <= '1;
            eot_q      <= 1'b0;
            word_cnt_q <= '0;
        end
        else
        begin
            eot_q <= 1'b0;
            case (state_q)
                IDLE:
                begin
                    if (cmd_valid_i)
                    begin
                        case (op)
                            OP_CFG:
                                div_q <= cmd_data_i[DIV_W-1:0];
                            OP_SOT:
                                csn_q <= ~(CS_N'(1) << cmd_data_i[CS_IDX_W-1:0]);
                            OP_EOT:
                            begin
                                csn_q <= '1;
                                eot_q <= cmd_data_i[0];
                            end
                            OP_SEND_CMD:
                            begin
                                word_cnt_q <= '0;
                                state_q    <= EXEC;
                            end
                            OP_TX_DATA, OP_RX_DATA:
                            begin
                                word_cnt_q <= cmd_data_i[CNT_W-1:0];
                                state_q    <= EXEC;
                            end
                            default: ;
                        endcase
                    end
                end
                EXEC:
                begin
                    if (shift.start)
                        state_q <= WAIT_WORD;
                end
                WAIT_WORD:
                begin
                    if (shift.done)
                    begin
                        if (word_cnt_q == '0)
                            state_q <= FINISH;
                        else
                        begin
                            word_cnt_q <= word_cnt_q - 1'b1;
                            state_q    <= EXEC;
                        end
                    end
                end
                FINISH:
                    state_q <= IDLE;
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    a_one_chip_selected : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(~spi_csn_o));

    // The shifter drops busy only on the cycle of done
    a_no_start_when_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        shift.start |-> !shift.busy);

endmodule

// ==== source/spim_fifo.sv ====
// Word FIFO, first word fall through
// Circular buffer with valid/ready handshakes on the push and pop sides

`timescale 1ns/100ps

module spim_fifo import spim_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic [WORD_W-1:0] push_data_i,
    input  logic              push_valid_i,
    output logic              push_ready_o,

    output logic [WORD_W-1:0] pop_data_o,
    output logic              pop_valid_o,
    input  logic              pop_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    logic [WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [OCC_W-1:0]  count_q;
    logic              push;
    logic              pop;

    assign push_ready_o = (count_q != OCC_W'(DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i)
    begin
        if (push)
            mem[wr_ptr_q] <= push_data_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            // Simultaneous push and pop keeps the count
            if (push && !pop)
                count_q <= count_q + 1'b1;
            else if (pop && !push)
                count_q <= count_q - 1'b1;
        end
    end

    a_count_in_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= OCC_W'(DEPTH));

endmodule

// ==== common/spim_shift_if.sv ====
// SPI master shift request channel
// Carries one word transfer from the sequencer to the shift engine and back

`timescale 1ns/100ps

interface spim_shift_if import spim_pkg::*; ();

    // Request side, captured by the shifter on start
    logic                start;
    logic [BITCNT_W-1:0] bits;
    logic [WORD_W-1:0]   tx_word;
    logic [DIV_W-1:0]    div;

    // Completion side
    logic                busy;
    logic                done;
    logic [WORD_W-1:0]   rx_word;

    modport seq
    (
        output start, bits, tx_word, div,
        input  busy, done, rx_word
    );

    modport shf
    (
        input  start, bits, tx_word, div,
        output busy, done, rx_word
    );

endinterface

// ==== common/spim_pkg.sv ====
// SPI master shared definitions
// Command opcodes, command field positions, widths, FIFO depths and FSM states

package spim_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int WORD_W   = 32;
    // Word bit counter, carries the bit count minus one (1 to 32 bits)
    localparam int BITCNT_W = 5;
    localparam int DIV_W    = 8;
    localparam int CNT_W    = 16;
    localparam int LIT_W    = 16;

    // Chip selects
    localparam int CS_N     = 4;
    localparam int CS_IDX_W = $clog2(CS_N);

    //////////////////////////////////////////////////
    // Command word fields
    //////////////////////////////////////////////////

    localparam int OP_MSB  = 31;
    localparam int OP_LSB  = 28;
    // Literal bit count minus one, bits 19 to 16 of OP_SEND_CMD
    localparam int LEN_LSB = 16;
    localparam int LEN_W   = 4;

    // Buffer depths
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int TX_FIFO_DEPTH  = 4;
    localparam int RX_FIFO_DEPTH  = 4;

    // SPI clock half period is DIV_RESET+1 cycles out of reset
    localparam int DIV_RESET = 3;

    typedef enum logic [3:0] {
        OP_CFG      = 4'd0,
        OP_SOT      = 4'd1,
        OP_SEND_CMD = 4'd2,
        OP_TX_DATA  = 4'd3,
        OP_RX_DATA  = 4'd4,
        OP_EOT      = 4'd5
    } spim_op_e;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        WAIT_WORD,
        FINISH
    } seq_state_e;

endpackage
